// File: Bender.yml
package:
  name: dadda_multiplier

sources:
  - verilog/mulPkg.sv
  - verilog/daddaPkg.sv
  - verilog/partialProducts.sv
  - verilog/daddaStage.sv
  - verilog/daddaTree.sv
  - verilog/rippleAdder.sv
  - verilog/daddaMultiplier.sv
  - target: test
    files:
      - testbench/tbClock.sv
      - testbench/tbDaddaMultiplier.sv

// File: testbench/mulTests.txt
// Directed vectors for 16-bit operands, one per line
// Columns: opA opB expected product, all in hex
0000 0000 00000000
ffff ffff fffe0001
0001 0001 00000001
0001 ffff 0000ffff
ffff 0001 0000ffff
0000 ffff 00000000
ffff 0000 00000000
8000 8000 40000000
8000 0001 00008000
8000 ffff 7fff8000
ffff 8000 7fff8000
aaaa 5555 38e31c72
aaaa aaaa 71c638e4
5555 5555 1c718e39
00ff ff00 00fe0100
ff00 ff00 fe010000
00ff 00ff 0000fe01
0f0f f0f0 0e2c2e10
1234 5678 06260060
0002 0003 00000006
0100 0100 00010000
8001 8001 40010001
7fff 7fff 3fff0001
fffe fffe fffc0004
ffff fffe fffd0002
0004 4000 00010000
0010 1000 00010000
1000 1000 01000000
0003 5555 0000ffff
00ff 0101 0000ffff
abcd 0001 0000abcd
0001 abcd 0000abcd
0002 8000 00010000
ffff 0002 0001fffe
c000 c000 90000000
8421 0001 00008421

// File: testbench/tbClock.sv
`timescale 1ns/100ps

module tbClock #(
  parameter int periodNs    = 8,
  parameter int resetCycles = 2
) (
  input  logic rstReq,
  output logic clk,
  output logic arstN
);

  logic porN;

  initial begin
    clk = 1'b0;
    forever #(periodNs/2) clk = ~clk;
  end

  // Power-on reset ends on a falling edge
  initial begin
    porN = 1'b0;
    repeat (resetCycles) @(posedge clk);
    @(negedge clk);
    porN = 1'b1;
  end

  assign arstN = porN & ~rstReq;

endmodule

// File: testbench/tbDaddaMultiplier.sv
`timescale 1ns/100ps

module tbDaddaMultiplier;

  localparam int opWidth    = mulPkg::defaultOpWidth;
  localparam int latency    = 3;
  localparam int maxVectors = 64;
  localparam int numBurst   = 32;
  localparam int numGapped  = 32;
  localparam int numMidRst  = 8;
  localparam int numRandom  = numBurst + numGapped + numMidRst;

  logic                 clk;
  logic                 arstN;
  logic                 rstReq;
  logic [opWidth-1:0]   opA;
  logic [opWidth-1:0]   opB;
  logic                 inValid;
  logic [2*opWidth-1:0] product;
  logic                 outValid;

  logic [2*opWidth-1:0] vecMem [3*maxVectors];
  logic [2*opWidth-1:0] expQ [$];
  logic [latency-1:0]   validHist;
  logic [31:0]          lcgState;
  int                   numVectors;
  int                   cycleCount;
  int                   cycleLimit;

  tbClock #(
    .periodNs   (8),
    .resetCycles(2)
  ) u_tbClock (
    .rstReq(rstReq),
    .clk   (clk),
    .arstN (arstN)
  );

  daddaMultiplier #(.opWidth(opWidth)) u_daddaMultiplier (
    .clk     (clk),
    .arstN   (arstN),
    .opA     (opA),
    .opB     (opB),
    .inValid (inValid),
    .product (product),
    .outValid(outValid)
  );

  function automatic logic [31:0] lcgNext(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic randomOperand(output logic [opWidth-1:0] val);
    lcgState = lcgNext(lcgState);
    val = lcgState[31 -: opWidth];
  endtask

  task automatic stopOnError(input string reason);
    $display("%s", reason);
    $display("SOME TESTS FAILED");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic checkProduct(input logic [2*opWidth-1:0] got,
                              input logic [2*opWidth-1:0] exp);
    if (got !== exp) begin
      stopOnError($sformatf("FAIL product exp %h got %h", exp, got));
    end
  endtask

  task automatic checkValid(input logic got, input logic exp);
    if (got !== exp) begin
      stopOnError($sformatf("FAIL outValid exp %h got %h", exp, got));
    end
  endtask

  // Check the settled outputs first, then drive the next inputs
  task automatic stepCycle(input logic valid, input logic [opWidth-1:0] a,
                           input logic [opWidth-1:0] b);
    logic [2*opWidth-1:0] exp;
    @(negedge clk);
    cycleCount++;
    if (cycleCount > cycleLimit) begin
      stopOnError($sformatf("Timeout: tests did not finish within %0d cycles", cycleLimit));
    end
    checkValid(outValid, validHist[latency-1]);
    if (!arstN) begin
      checkProduct(product, '0);
    end else if (outValid) begin
      if (expQ.size() == 0) begin
        stopOnError("outValid was high while no product was outstanding");
      end
      exp = expQ.pop_front();
      checkProduct(product, exp);
    end
    inValid   = valid;
    opA       = a;
    opB       = b;
    validHist = {validHist[latency-2:0], valid};
  endtask

  task automatic idleCycle();
    stepCycle(1'b0, '0, '0);
  endtask

  task automatic issuePair(input logic [opWidth-1:0] a, input logic [opWidth-1:0] b,
                           input logic [2*opWidth-1:0] exp);
    expQ.push_back(exp);
    stepCycle(1'b1, a, b);
  endtask

  task automatic issueRandom();
    logic [opWidth-1:0]   a;
    logic [opWidth-1:0]   b;
    logic [2*opWidth-1:0] exp;
    randomOperand(a);
    randomOperand(b);
    exp = {{opWidth{1'b0}}, a} * {{opWidth{1'b0}}, b};
    issuePair(a, b, exp);
  endtask

  task automatic drainPipe();
    while (expQ.size() != 0) begin
      idleCycle();
    end
  endtask

  task automatic resetMidStream();
    for (int n = 0; n < numMidRst - 2; n++) begin
      issueRandom();
    end
    // Pipeline full, outValid high
    rstReq = 1'b1;
    #1;
    checkValid(outValid, 1'b0);
    checkProduct(product, '0);
    expQ.delete();
    validHist = '0;
    repeat (2) idleCycle();
    rstReq = 1'b0;
    repeat (2*latency) idleCycle();
    for (int n = 0; n < 2; n++) begin
      issueRandom();
    end
    drainPipe();
  endtask

  initial begin
    rstReq     = 1'b0;
    inValid    = 1'b0;
    opA        = '0;
    opB        = '0;
    validHist  = '0;
    cycleCount = 0;
    lcgState   = 32'h5e55_5086;
    $readmemh("testbench/mulTests.txt", vecMem);
    numVectors = 0;
    while (numVectors < maxVectors && !$isunknown(vecMem[3*numVectors])) begin
      numVectors++;
    end
    if (numVectors == 0) begin
      stopOnError("No test vectors were found in testbench/mulTests.txt");
    end
    cycleLimit = (numVectors + numRandom + latency) * 2;

    // Reset and the first cycles after it
    repeat (latency + 2) idleCycle();

    for (int n = 0; n < numVectors; n++) begin
      issuePair(vecMem[3*n][opWidth-1:0], vecMem[3*n+1][opWidth-1:0], vecMem[3*n+2]);
    end
    drainPipe();

    for (int n = 0; n < numBurst; n++) begin
      issueRandom();
    end
    drainPipe();

    // Random idle cycles between strobes
    for (int n = 0; n < numGapped; n++) begin
      lcgState = lcgNext(lcgState);
      if (lcgState[30]) begin
        idleCycle();
      end
      issueRandom();
    end
    drainPipe();

    resetMidStream();

    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

// File: verilog/daddaMultiplier.sv
`timescale 1ns/100ps

module daddaMultiplier #(
  parameter int opWidth = mulPkg::defaultOpWidth
) (
  input  logic                 clk,
  input  logic                 arstN,
  input  logic [opWidth-1:0]   opA,
  input  logic [opWidth-1:0]   opB,
  input  logic                 inValid,
  output logic [2*opWidth-1:0] product,
  output logic                 outValid
);

  mulPkg::columnMatrix  ppCols;
  logic                 ppValid;
  logic [2*opWidth-1:0] rowA;
  logic [2*opWidth-1:0] rowB;
  logic                 rowValid;

  // Column matrix type has a fixed upper size
  if (opWidth > mulPkg::maxOpWidth) begin : gWidthCheck
    $error("opWidth exceeds mulPkg::maxOpWidth");
  end

  partialProducts #(.opWidth(opWidth)) u_partialProducts (
    .clk    (clk),
    .arstN  (arstN),
    .opA    (opA),
    .opB    (opB),
    .inValid(inValid),
    .ppCols (ppCols),
    .ppValid(ppValid)
  );

  daddaTree #(.opWidth(opWidth)) u_daddaTree (
    .clk     (clk),
    .arstN   (arstN),
    .ppCols  (ppCols),
    .ppValid (ppValid),
    .rowA    (rowA),
    .rowB    (rowB),
    .rowValid(rowValid)
  );

  rippleAdder #(.width(2*opWidth)) u_rippleAdder (
    .clk     (clk),
    .arstN   (arstN),
    .rowA    (rowA),
    .rowB    (rowB),
    .rowValid(rowValid),
    .product (product),
    .outValid(outValid)
  );

endmodule

// File: verilog/daddaPkg.sv
package daddaPkg;

  // Limits 2, 3, 4, 6, 9, 13, 19, 28
  function automatic int daddaHeight(input int n);
    int d;
    d = 2;
    for (int k = 0; k < n; k++) begin
      d = d * 3 / 2;
    end
    return d;
  endfunction

  // Stages from opWidth rows down to two
  function automatic int numStages(input int opWidth);
    int n;
    n = 0;
    while (daddaHeight(n) < opWidth) begin
      n++;
    end
    return n;
  endfunction

  // Replays the reduction from the AND array up to the given stage
  // kind 0 gives the column height, 1 the full adders, 2 the half adders
  function automatic int reduceCount(input int opWidth, input int stage, input int col,
                                     input int kind);
    int height [2*mulPkg::maxOpWidth];
    int target;
    int carryIn;
    int excess;
    int nFa;
    int nHa;
    for (int c = 0; c < 2*opWidth; c++) begin
      height[c] = (c < opWidth) ? c + 1 : 2*opWidth - 1 - c;
    end
    for (int s = 0; s <= stage; s++) begin
      target = daddaHeight(numStages(opWidth) - 1 - s);
      carryIn = 0;
      for (int c = 0; c < 2*opWidth; c++) begin
        // Only as many counters as it takes to hit the target
        excess = height[c] + carryIn - target;
        nFa = (excess > 0) ? excess / 2 : 0;
        nHa = (excess > 0) ? excess % 2 : 0;
        if (s == stage && c == col) begin
          return (kind == 0) ? height[c] : ((kind == 1) ? nFa : nHa);
        end
        height[c] = height[c] + carryIn - 2*nFa - nHa;
        carryIn = nFa + nHa;
      end
    end
    return 0;
  endfunction

  function automatic int columnHeight(input int opWidth, input int stage, input int col);
    return reduceCount(opWidth, stage, col, 0);
  endfunction

  function automatic int fullAdders(input int opWidth, input int stage, input int col);
    return reduceCount(opWidth, stage, col, 1);
  endfunction

  function automatic int halfAdders(input int opWidth, input int stage, input int col);
    return reduceCount(opWidth, stage, col, 2);
  endfunction

endpackage

// File: verilog/daddaStage.sv
`timescale 1ns/100ps

module daddaStage #(
  parameter int opWidth = mulPkg::defaultOpWidth,
  parameter int stage   = 0
) (
  input  mulPkg::columnMatrix colsIn,
  output mulPkg::columnMatrix colsOut
);

  localparam int numCols = 2 * opWidth;
  localparam int maxH    = mulPkg::maxColHeight;

  for (genvar c = 0; c < 2*mulPkg::maxOpWidth; c++) begin : gCol
    if (c < numCols) begin : gUsed
      localparam int lowCol = (c > 0) ? c - 1 : 0;
      localparam int nFa    = daddaPkg::fullAdders(opWidth, stage, c);
      localparam int nHa    = daddaPkg::halfAdders(opWidth, stage, c);
      localparam int nPass  = daddaPkg::columnHeight(opWidth, stage, c) - 3*nFa - 2*nHa;
      // Counters of the column below, whose carries land here
      localparam int lowFa  = (c > 0) ? daddaPkg::fullAdders(opWidth, stage, lowCol) : 0;
      localparam int lowHa  = (c > 0) ? daddaPkg::halfAdders(opWidth, stage, lowCol) : 0;
      localparam int sumTop = nPass + nFa + nHa;

      logic [maxH-1:0] colBits;

      always_comb begin
        logic [2:0] trio;
        logic [1:0] pair;
        trio    = '0;
        pair    = '0;
        colBits = '0;
        // Bits above the counters move through unchanged
        for (int k = 0; k < nPass; k++) begin
          colBits[k] = colsIn[c][3*nFa + 2*nHa + k];
        end
        for (int k = 0; k < nFa; k++) begin
          trio = colsIn[c][3*k +: 3];
          colBits[nPass + k] = ^trio;
        end
        for (int k = 0; k < nHa; k++) begin
          pair = colsIn[c][3*nFa + 2*k +: 2];
          colBits[nPass + nFa + k] = ^pair;
        end
        // Carries from the column below
        for (int k = 0; k < lowFa; k++) begin
          trio = colsIn[lowCol][3*k +: 3];
          colBits[sumTop + k] = (trio[0] & trio[1]) | ((trio[0] ^ trio[1]) & trio[2]);
        end
        for (int k = 0; k < lowHa; k++) begin
          pair = colsIn[lowCol][3*lowFa + 2*k +: 2];
          colBits[sumTop + lowFa + k] = &pair;
        end
      end

      assign colsOut[c] = colBits;
    end else begin : gUnused
      assign colsOut[c] = '0;
    end
  end

endmodule

// File: verilog/daddaTree.sv
`timescale 1ns/100ps

module daddaTree #(
  parameter int opWidth = mulPkg::defaultOpWidth
) (
  input  logic                 clk,
  input  logic                 arstN,
  input  mulPkg::columnMatrix  ppCols,
  input  logic                 ppValid,
  output logic [2*opWidth-1:0] rowA,
  output logic [2*opWidth-1:0] rowB,
  output logic                 rowValid
);

  localparam int nStages = daddaPkg::numStages(opWidth);
  localparam int maxH    = mulPkg::maxColHeight;

  mulPkg::columnMatrix  stageCols [nStages+1];
  logic [2*opWidth-1:0] rowANext;
  logic [2*opWidth-1:0] rowBNext;
  logic [2*opWidth-1:0] tallCol;

  assign stageCols[0] = ppCols;

  // Heights 13, 9, 6, 4, 3, 2 at 16 bits
  for (genvar s = 0; s < nStages; s++) begin : gStage
    daddaStage #(
      .opWidth(opWidth),
      .stage  (s)
    ) u_daddaStage (
      .colsIn (stageCols[s]),
      .colsOut(stageCols[s+1])
    );
  end

  for (genvar c = 0; c < 2*opWidth; c++) begin : gRow
    assign rowANext[c] = stageCols[nStages][c][0];
    assign rowBNext[c] = stageCols[nStages][c][1];
    assign tallCol[c]  = |stageCols[nStages][c][maxH-1:2];
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      rowA     <= '0;
      rowB     <= '0;
      rowValid <= 1'b0;
    end else begin
      rowA     <= rowANext;
      rowB     <= rowBNext;
      rowValid <= ppValid;
    end
  end

  // Whole chain must end with at most two bits per column
  assert property (@(posedge clk) disable iff (!arstN) ppValid |-> tallCol == '0)
    else $error("Dadda tree left a column taller than two bits");

endmodule

// File: verilog/mulPkg.sv
package mulPkg;

  // Operand width of the top level unless overridden
  localparam int defaultOpWidth = 16;

  // Largest operand width the column matrix can hold
  localparam int maxOpWidth = 32;

  // Tallest column of the AND array
  function automatic int maxHeight(input int opWidth);
    return opWidth;
  endfunction

  localparam int maxColHeight = maxHeight(maxOpWidth);

  // Column index first, then bit position in the column
  // Columns and bits beyond the current width stay zero
  typedef logic [2*maxOpWidth-1:0][maxColHeight-1:0] columnMatrix;

endpackage

// File: verilog/partialProducts.sv
`timescale 1ns/100ps

module partialProducts #(
  parameter int opWidth = mulPkg::defaultOpWidth
) (
  input  logic                clk,
  input  logic                arstN,
  input  logic [opWidth-1:0]  opA,
  input  logic [opWidth-1:0]  opB,
  input  logic                inValid,
  output mulPkg::columnMatrix ppCols,
  output logic                ppValid
);

  mulPkg::columnMatrix ppNext;

  // Column c collects A[i]&B[j] with i+j == c, stacked from bit 0
  for (genvar c = 0; c < 2*mulPkg::maxOpWidth; c++) begin : gCol
    for (genvar r = 0; r < mulPkg::maxColHeight; r++) begin : gRow
      localparam int i = r + ((c >= opWidth) ? c - opWidth + 1 : 0);
      localparam int j = c - i;
      if (i < opWidth && j >= 0 && j < opWidth) begin : gAnd
        assign ppNext[c][r] = opA[i] & opB[j];
      end else begin : gZero
        assign ppNext[c][r] = 1'b0;
      end
    end
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      ppCols  <= '0;
      ppValid <= 1'b0;
    end else begin
      ppCols  <= ppNext;
      ppValid <= inValid;
    end
  end

endmodule

// File: verilog/rippleAdder.sv
`timescale 1ns/100ps

module rippleAdder #(
  parameter int width = 2 * mulPkg::defaultOpWidth
) (
  input  logic             clk,
  input  logic             arstN,
  input  logic [width-1:0] rowA,
  input  logic [width-1:0] rowB,
  input  logic             rowValid,
  output logic [width-1:0] product,
  output logic             outValid
);

  logic [width:0]   carry;
  logic [width-1:0] sum;

  assign carry[0] = 1'b0;

  for (genvar k = 0; k < width; k++) begin : gCell
    assign sum[k]     = rowA[k] ^ rowB[k] ^ carry[k];
    assign carry[k+1] = (rowA[k] & rowB[k]) | ((rowA[k] ^ rowB[k]) & carry[k]);
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      product  <= '0;
      outValid <= 1'b0;
    end else begin
      product  <= sum;
      outValid <= rowValid;
    end
  end

  // Product of two opWidth operands never needs the extra bit
  assert property (@(posedge clk) disable iff (!arstN) rowValid |-> !carry[width])
    else $error("Final adder carried out of the product width");

endmodule

// File: vlog.f
verilog/mulPkg.sv
verilog/daddaPkg.sv
verilog/partialProducts.sv
verilog/daddaStage.sv
verilog/daddaTree.sv
verilog/rippleAdder.sv
verilog/daddaMultiplier.sv
testbench/tbClock.sv
testbench/tbDaddaMultiplier.sv
